// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_nes_boot \
		-f filelist.f -o sim_nes_boot
	-./obj_dir/sim_nes_boot > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: boot_sequencer.sv
// SD block read sequencer
`timescale 1ns/1ps
`include "nes_boot_config.svh"

module boot_sequencer (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  sd_block_pkg::sd_read_rsp_t sd_rsp_i,
    input  logic                       receiver_ready_i,
    input  logic                       header_done_i,
    input  logic                       data_received_i,
    output sd_block_pkg::sd_read_req_t sd_req_o,
    output logic                       header_phase_o,
    output logic                       data_phase_o,
    output logic                       complete_o
);
    import sd_block_pkg::*;

    typedef enum logic [3:0] {
        WAIT_READY,
        PREPARE_HEADER_READ,
        READING_HEADER,
        IDLE,
        PREPARE_DATA_READ,
        READING_DATA,
        CHECK_BLOCK,
        UNEXPECTED_RESULT,
        FINISHED
    } state_t;

    state_t                      state_r;
    state_t                      state_next;
    logic                        ready_to_read;
    logic                        start_read;
    logic                        start_r;
    logic [`SD_BLOCK_ADDR_W-1:0] block_addr_r;
    logic                        result_ok_r;
    logic                        read_finished_r;
    logic                        complete_r;

    assign ready_to_read = sd_rsp_i.idle & receiver_ready_i;

    always_comb begin
        state_next = state_r;
        case (state_r)
            WAIT_READY: begin
                if (ready_to_read) begin
                    state_next = PREPARE_HEADER_READ;
                end
            end
            PREPARE_HEADER_READ: begin
                state_next = READING_HEADER;
            end
            READING_HEADER: begin
                if (header_done_i) begin
                    state_next = READING_DATA;  // Rest of block 0 is ROM data
                end
            end
            IDLE: begin
                if (data_received_i) begin
                    state_next = FINISHED;
                end else if (ready_to_read) begin
                    state_next = PREPARE_DATA_READ;
                end
            end
            PREPARE_DATA_READ: begin
                state_next = READING_DATA;
            end
            READING_DATA: begin
                if (sd_rsp_i.idle) begin
                    state_next = CHECK_BLOCK;
                end
            end
            CHECK_BLOCK: begin
                state_next = result_ok_r ? IDLE : UNEXPECTED_RESULT;
            end
            UNEXPECTED_RESULT: begin
                state_next = FINISHED;
            end
            FINISHED: begin
                state_next = FINISHED;
            end
            default: begin
                state_next = WAIT_READY;
            end
        endcase
    end

    assign start_read = (state_next == PREPARE_HEADER_READ) |
                        (state_next == PREPARE_DATA_READ);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r         <= WAIT_READY;
            start_r         <= 1'b0;
            read_finished_r <= 1'b0;
            complete_r      <= 1'b0;
        end else begin
            state_r         <= state_next;
            start_r         <= start_read;  // Pulse lands in the PREPARE state
            read_finished_r <= read_finished_r | (state_next == FINISHED);
            complete_r      <= complete_r |
                               (data_received_i & read_finished_r & sd_rsp_i.powered_down);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_next == PREPARE_HEADER_READ) begin
            block_addr_r <= '0;  // Header sits in block 0
        end else if (state_next == PREPARE_DATA_READ) begin
            block_addr_r <= block_addr_r + `SD_BLOCK_ADDR_W'(1);
        end
        if (state_next == CHECK_BLOCK) begin
            result_ok_r <= sd_rsp_i.result_ok;  // Card is idle with the result here
        end
    end

    assign sd_req_o = sd_read_req_t'{
        start:         start_r,
        block_addr:    block_addr_r,
        read_finished: read_finished_r
    };

    assign header_phase_o = (state_next == READING_HEADER);
    assign data_phase_o   = (state_next == READING_DATA);
    assign complete_o     = complete_r;

    // The card must still be idle when the registered start reaches it
    a_start_only_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        sd_req_o.start |-> sd_rsp_i.idle);

    a_complete_after_finish: assert property (@(posedge clk_i) disable iff (rst_i)
        complete_o |-> sd_req_o.read_finished);

endmodule

// File: filelist.f
+incdir+.
sd_block_pkg.sv
ines_pkg.sv
boot_sequencer.sv
ines_header_parser.sv
rom_stream_tracker.sv
nes_boot_top.sv
tb_sd_card_model.sv
tb_nes_boot.sv

// File: ines_header_parser.sv
// iNES header field capture
`timescale 1ns/1ps
`include "nes_boot_config.svh"

module ines_header_parser (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       header_phase_i,
    input  sd_block_pkg::sd_read_rsp_t sd_rsp_i,
    output logic                       header_done_o,
    output ines_pkg::cart_info_t       cart_info_o
);
    import ines_pkg::*;

    localparam logic [`SD_BYTE_IDX_W-1:0] PRG_IDX    = `NES_HDR_PRG_BYTE;
    localparam logic [`SD_BYTE_IDX_W-1:0] CHR_IDX    = `NES_HDR_CHR_BYTE;
    localparam logic [`SD_BYTE_IDX_W-1:0] FLAGS6_IDX = `NES_HDR_FLAGS6_BYTE;
    localparam logic [`SD_BYTE_IDX_W-1:0] FLAGS7_IDX = `NES_HDR_FLAGS7_BYTE;
    localparam logic [`SD_BYTE_IDX_W-1:0] LAST_IDX   = `NES_HEADER_LEN - 1;

    logic                       hdr_byte;
    logic [`NES_BANK_NUM_W-1:0] prg_banks_r;
    logic [`NES_BANK_NUM_W-1:0] chr_banks_r;
    logic                       header_done_r;
    logic [3:0]                 mapper_lo_r;
    logic [3:0]                 mapper_hi_r;
    logic                       hw_nt_r;
    logic                       alt_nt_r;

    assign hdr_byte = header_phase_i & sd_rsp_i.byte_valid;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prg_banks_r   <= '0;
            chr_banks_r   <= '0;
            header_done_r <= 1'b0;
        end else if (hdr_byte) begin
            case (sd_rsp_i.byte_index)
                PRG_IDX:  prg_banks_r   <= sd_rsp_i.data[`NES_BANK_NUM_W-1:0];
                CHR_IDX:  chr_banks_r   <= sd_rsp_i.data[`NES_BANK_NUM_W-1:0];
                LAST_IDX: header_done_r <= 1'b1;
                default:  ;
            endcase
        end
    end

    // Flag bytes 6 and 7
    always_ff @(posedge clk_i) begin
        if (hdr_byte && sd_rsp_i.byte_index == FLAGS6_IDX) begin
            hw_nt_r     <= sd_rsp_i.data[0];
            alt_nt_r    <= sd_rsp_i.data[3];
            mapper_lo_r <= sd_rsp_i.data[7:4];
        end
        if (hdr_byte && sd_rsp_i.byte_index == FLAGS7_IDX) begin
            mapper_hi_r <= sd_rsp_i.data[7:4];
        end
    end

    assign cart_info_o = cart_info_t'{
        prg_banks:     prg_banks_r,
        chr_banks:     chr_banks_r,
        chr_is_rom:    |chr_banks_r,
        chr_is_ram:    ~|chr_banks_r,   // Zero CHR banks means board RAM
        mapper:        {mapper_hi_r, mapper_lo_r},
        hw_nametable:  hw_nt_r,
        alt_nametable: alt_nt_r
    };

    assign header_done_o = header_done_r;

    a_info_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        header_done_o |=> $stable(cart_info_o));

endmodule

// File: ines_pkg.sv
// Cartridge and boot data types
`include "nes_boot_config.svh"

package ines_pkg;

    // Decoded iNES header
    typedef struct packed {
        logic [`NES_BANK_NUM_W-1:0] prg_banks;      // 16 KiB units
        logic [`NES_BANK_NUM_W-1:0] chr_banks;      // 8 KiB units
        logic                       chr_is_rom;
        logic                       chr_is_ram;     // No CHR banks in the image
        logic [7:0]                 mapper;
        logic                       hw_nametable;   // 0 horizontal, 1 vertical
        logic                       alt_nametable;
    } cart_info_t;

    // One ROM byte with its offset in the region
    typedef struct packed {
        logic [`NES_ROM_ADDR_W-1:0] addr;
        logic [7:0]                 data;
    } boot_data_t;

    // Boot progress flags
    typedef struct packed {
        logic booting;
        logic complete;
        logic prg_received;
        logic chr_received;
    } boot_status_t;

endpackage

// File: nes_boot_config.svh
// NES boot configuration
`ifndef NES_BOOT_CONFIG_SVH
`define NES_BOOT_CONFIG_SVH

// iNES header layout
`define NES_HEADER_LEN       16
`define NES_HDR_PRG_BYTE     4   // PRG bank count
`define NES_HDR_CHR_BYTE     5   // CHR bank count
`define NES_HDR_FLAGS6_BYTE  6   // Nametable bits and low mapper nibble
`define NES_HDR_FLAGS7_BYTE  7   // High mapper nibble

// Bank sizes as shifts
`define NES_PRG_BANK_SHIFT   14  // 16 KiB PRG banks
`define NES_CHR_BANK_SHIFT   13  // 8 KiB CHR banks

// ROM widths
`define NES_BANK_NUM_W       6
`define NES_ROM_ADDR_W       19

// SD block-read link widths
`define SD_BLOCK_ADDR_W      32
`define SD_BYTE_IDX_W        9   // 512 bytes per block

`endif

// File: nes_boot_top.sv
// NES cartridge boot top level
`timescale 1ns/1ps

module nes_boot_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  sd_block_pkg::sd_read_rsp_t sd_rsp_i,
    output sd_block_pkg::sd_read_req_t sd_req_o,
    input  logic                       receiver_ready_i,
    output ines_pkg::cart_info_t       cart_info_o,
    output ines_pkg::boot_data_t       boot_data_o,
    output logic                       boot_data_valid_o,
    output ines_pkg::boot_status_t     status_o
);
    import ines_pkg::*;

    logic header_phase;
    logic data_phase;
    logic header_done;
    logic data_received;
    logic prg_received;
    logic chr_received;
    logic complete;

    boot_sequencer u_sequencer (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .sd_rsp_i         (sd_rsp_i),
        .receiver_ready_i (receiver_ready_i),
        .header_done_i    (header_done),
        .data_received_i  (data_received),
        .sd_req_o         (sd_req_o),
        .header_phase_o   (header_phase),
        .data_phase_o     (data_phase),
        .complete_o       (complete)
    );

    ines_header_parser u_parser (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .header_phase_i (header_phase),
        .sd_rsp_i       (sd_rsp_i),
        .header_done_o  (header_done),
        .cart_info_o    (cart_info_o)
    );

    rom_stream_tracker u_tracker (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .data_phase_i      (data_phase),
        .header_done_i     (header_done),
        .sd_rsp_i          (sd_rsp_i),
        .cart_info_i       (cart_info_o),
        .data_received_o   (data_received),
        .prg_received_o    (prg_received),
        .chr_received_o    (chr_received),
        .boot_data_o       (boot_data_o),
        .boot_data_valid_o (boot_data_valid_o)
    );

    assign status_o = boot_status_t'{
        booting:      ~complete,  // Held until the card is powered down
        complete:     complete,
        prg_received: prg_received,
        chr_received: chr_received
    };

endmodule

// File: rom_stream_tracker.sv
// PRG and CHR byte stream tracker
`timescale 1ns/1ps
`include "nes_boot_config.svh"

module rom_stream_tracker (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       data_phase_i,
    input  logic                       header_done_i,
    input  sd_block_pkg::sd_read_rsp_t sd_rsp_i,
    input  ines_pkg::cart_info_t       cart_info_i,
    output logic                       data_received_o,
    output logic                       prg_received_o,
    output logic                       chr_received_o,
    output ines_pkg::boot_data_t       boot_data_o,
    output logic                       boot_data_valid_o
);
    import ines_pkg::*;

    localparam int ROM_W  = `NES_ROM_ADDR_W;
    localparam int PRG_SZ_W = ROM_W + 1;  // 63 PRG banks need one bit more

    logic [ROM_W-1:0]    rom_offset_r;
    logic [PRG_SZ_W-1:0] prg_last;
    logic [ROM_W-1:0]    chr_last;
    logic                data_received;
    logic                rom_byte;
    logic                prg_done;
    logic                chr_done;
    logic                prg_received_r;
    logic                chr_received_r;

    // Offsets of the last byte in each region
    assign prg_last = (PRG_SZ_W'(cart_info_i.prg_banks) << `NES_PRG_BANK_SHIFT) -
                      PRG_SZ_W'(1);
    assign chr_last = (ROM_W'(cart_info_i.chr_banks) << `NES_CHR_BANK_SHIFT) -
                      ROM_W'(1);

    assign data_received = prg_received_r & chr_received_r;
    assign rom_byte      = data_phase_i & sd_rsp_i.byte_valid & ~data_received;

    assign prg_done = rom_byte & ~prg_received_r & ({1'b0, rom_offset_r} == prg_last);
    assign chr_done = (rom_byte & prg_received_r & (rom_offset_r == chr_last)) |
                      (cart_info_i.chr_is_ram & header_done_i);  // Nothing to load

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rom_offset_r   <= '0;
            prg_received_r <= 1'b0;
            chr_received_r <= 1'b0;
        end else begin
            if (prg_done) begin
                rom_offset_r <= '0;  // CHR offsets restart at zero
            end else if (rom_byte) begin
                rom_offset_r <= rom_offset_r + ROM_W'(1);
            end
            prg_received_r <= prg_received_r | prg_done;
            chr_received_r <= chr_received_r | chr_done;
        end
    end

    assign boot_data_o = boot_data_t'{
        addr: rom_offset_r,
        data: sd_rsp_i.data
    };

    assign boot_data_valid_o = rom_byte;
    assign data_received_o   = data_received;
    assign prg_received_o    = prg_received_r;
    assign chr_received_o    = chr_received_r;

    // Once the image is in, the stream stays closed
    a_no_beat_after_done: assert property (@(posedge clk_i) disable iff (rst_i)
        data_received_o |=> (data_received_o && !boot_data_valid_o));

endmodule

// File: sd_block_pkg.sv
// SD block-read link types
`include "nes_boot_config.svh"

package sd_block_pkg;

    // Request from the boot logic to the card
    typedef struct packed {
        logic                        start;          // One-cycle read pulse
        logic [`SD_BLOCK_ADDR_W-1:0] block_addr;     // Block number on the card
        logic                        read_finished;  // Level, card may power down
    } sd_read_req_t;

    // Response from the card
    typedef struct packed {
        logic                        idle;           // No block read in progress
        logic                        result_ok;      // Valid while idle after a read
        logic                        byte_valid;     // Strobe for one data byte
        logic [`SD_BYTE_IDX_W-1:0]   byte_index;     // Position inside the block
        logic [7:0]                  data;
        logic                        powered_down;
    } sd_read_rsp_t;

endpackage

// File: tb_nes_boot.sv
// NES boot testbench
`timescale 1ns/1ps
`include "nes_boot_config.svh"

module tb_nes_boot;
    import sd_block_pkg::*;
    import ines_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int MAX_GAP       = 3;
    localparam int IMAGE_DEPTH   = 65536;
    localparam int MAX_BLOCKS    = 49;   // 16 + 16384 + 8192 bytes
    localparam int SCENARIOS     = 4;
    localparam int SETTLE_CYCLES = 200;
    localparam int TIMEOUT_CYCLES = MAX_BLOCKS * 512 * (MAX_GAP + 2) * SCENARIOS + 20000;
    localparam logic [`SD_BLOCK_ADDR_W-1:0] FAIL_BLOCK = 10;  // Inside the PRG region

    logic         clk;
    logic         rst;
    logic         receiver_ready = 1'b0;
    logic         back_pressure;
    logic         fail_en;
    sd_read_req_t sd_req;
    sd_read_rsp_t sd_rsp;
    cart_info_t   cart_info;
    boot_data_t   boot_data;
    logic         boot_data_valid;
    boot_status_t status;
    logic [7:0]   img [0:IMAGE_DEPTH-1];
    int           beats;
    int           cycles = 0;
    logic         ready_last;
    logic         prg_seen;
    logic         chr_seen;
    logic         complete_seen;

    nes_boot_top dut_i (
        .clk_i             (clk),
        .rst_i             (rst),
        .sd_rsp_i          (sd_rsp),
        .sd_req_o          (sd_req),
        .receiver_ready_i  (receiver_ready),
        .cart_info_o       (cart_info),
        .boot_data_o       (boot_data),
        .boot_data_valid_o (boot_data_valid),
        .status_o          (status)
    );

    tb_sd_card_model #(.MAX_GAP (MAX_GAP), .IMAGE_DEPTH (IMAGE_DEPTH)) u_card (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_i        (sd_req),
        .fail_en_i    (fail_en),
        .fail_block_i (FAIL_BLOCK),
        .rsp_o        (sd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        receiver_ready <= back_pressure ? (($urandom % 4) != 0) : 1'b1;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic cart_info_t decode_header();
        cart_info_t info;
        info.prg_banks     = img[`NES_HDR_PRG_BYTE][`NES_BANK_NUM_W-1:0];
        info.chr_banks     = img[`NES_HDR_CHR_BYTE][`NES_BANK_NUM_W-1:0];
        info.chr_is_rom    = |img[`NES_HDR_CHR_BYTE][`NES_BANK_NUM_W-1:0];
        info.chr_is_ram    = ~|img[`NES_HDR_CHR_BYTE][`NES_BANK_NUM_W-1:0];
        info.mapper        = {img[`NES_HDR_FLAGS7_BYTE][7:4], img[`NES_HDR_FLAGS6_BYTE][7:4]};
        info.hw_nametable  = img[`NES_HDR_FLAGS6_BYTE][0];
        info.alt_nametable = img[`NES_HDR_FLAGS6_BYTE][3];
        return info;
    endfunction

    function automatic int prg_bytes();
        return int'(img[`NES_HDR_PRG_BYTE][`NES_BANK_NUM_W-1:0]) << `NES_PRG_BANK_SHIFT;
    endfunction

    function automatic int chr_bytes();
        return int'(img[`NES_HDR_CHR_BYTE][`NES_BANK_NUM_W-1:0]) << `NES_CHR_BANK_SHIFT;
    endfunction

    function automatic logic in_chr_region(input int n);
        return n >= prg_bytes();
    endfunction

    // Beat n is image byte n after the header, offset restarts at the CHR boundary
    function automatic boot_data_t expected_beat(input int n);
        boot_data_t beat;
        beat.addr = in_chr_region(n) ? `NES_ROM_ADDR_W'(n - prg_bytes()) : `NES_ROM_ADDR_W'(n);
        beat.data = img[16'(`NES_HEADER_LEN + n)];
        return beat;
    endfunction

    task automatic compare_cart_info(input string name, input cart_info_t got,
                                     input cart_info_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_boot_data(input string name, input boot_data_t got,
                                   input boot_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic verify_status(input string name, input boot_status_t got,
                                 input boot_status_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Compares every beat and the status edges against the image
    always @(negedge clk) begin
        if (rst) begin
            beats         = 0;
            prg_seen      = 1'b0;
            chr_seen      = 1'b0;
            complete_seen = 1'b0;
        end else begin
            if (sd_req.start && !ready_last) begin
                report_failure("Start was issued while the receiver was not ready");
            end
            if (sd_req.start && sd_req.read_finished) begin
                report_failure("Start was issued after the reads were finished");
            end
            if (status.booting == status.complete) begin
                report_failure("Status booting is not the inverse of complete");
            end
            if (status.prg_received && !prg_seen) begin
                if (beats != prg_bytes()) begin
                    report_failure($sformatf("prg_received rose after %0d beats", beats));
                end
                prg_seen = 1'b1;
            end
            if (status.chr_received && !chr_seen) begin
                if (chr_bytes() != 0 && beats != prg_bytes() + chr_bytes()) begin
                    report_failure($sformatf("chr_received rose after %0d beats", beats));
                end
                if (chr_bytes() == 0 && prg_seen) begin
                    report_failure("chr_received for a CHR RAM image came after the PRG data");
                end
                chr_seen = 1'b1;
            end
            if (status.complete && !complete_seen) begin
                if (!sd_rsp.powered_down || beats != prg_bytes() + chr_bytes()) begin
                    report_failure("Boot completed before all data arrived or power-down");
                end
                complete_seen = 1'b1;
            end
            if (boot_data_valid) begin
                if (beats >= prg_bytes() + chr_bytes()) begin
                    report_failure("A boot data beat came after all ROM data was received");
                end
                if (beats == 0) begin
                    compare_cart_info("cart_info_o", cart_info, decode_header());
                end
                check_boot_data("boot_data_o", boot_data, expected_beat(beats));
                beats++;
            end
        end
        ready_last = receiver_ready;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout, boot not done after %0d cycles", cycles));
        end
    end

    task automatic load_image(input logic [5:0] chr_banks);
        for (int i = 0; i < IMAGE_DEPTH; i++) begin
            img[16'(i)] = 8'($urandom);
        end
        img[0] = 8'h4e;  // "NES" and EOF mark
        img[1] = 8'h45;
        img[2] = 8'h53;
        img[3] = 8'h1a;
        img[`NES_HDR_PRG_BYTE]    = 8'd1;
        img[`NES_HDR_CHR_BYTE]    = {2'b00, chr_banks};
        img[`NES_HDR_FLAGS6_BYTE] = img[`NES_HDR_FLAGS6_BYTE] & 8'hfb;  // No trainer
        for (int i = 8; i < `NES_HEADER_LEN; i++) begin
            img[16'(i)] = 8'h00;
        end
        for (int i = 0; i < IMAGE_DEPTH; i++) begin
            u_card.image[16'(i)] = img[16'(i)];
        end
    endtask

    task automatic run_scenario(input logic [5:0] chr_banks, input logic bp, input logic fail);
        @(posedge clk);
        rst           <= 1'b1;
        back_pressure <= bp;
        fail_en       <= fail;
        load_image(chr_banks);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        if (fail) begin
            while (!(sd_req.read_finished && sd_rsp.powered_down)) @(negedge clk);
            repeat (SETTLE_CYCLES) @(negedge clk);
            verify_status("status_o", status, boot_status_t'(4'b1000));  // Still booting
        end else begin
            while (!status.complete) @(negedge clk);
            repeat (SETTLE_CYCLES) @(negedge clk);
            verify_status("status_o", status, boot_status_t'(4'b0111));
            compare_cart_info("cart_info_o", cart_info, decode_header());
        end
    endtask

    initial begin
        void'($urandom(74));
        rst           <= 1'b1;
        back_pressure <= 1'b0;
        fail_en       <= 1'b0;
        run_scenario(6'd1, 1'b0, 1'b0);  // CHR ROM image
        run_scenario(6'd0, 1'b0, 1'b0);  // CHR RAM image
        run_scenario(6'd1, 1'b1, 1'b0);  // Receiver drops ready at random
        run_scenario(6'd1, 1'b0, 1'b1);  // Card fails one block
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb_sd_card_model.sv
// SD card block-read model
`timescale 1ns/1ps
`include "nes_boot_config.svh"

module tb_sd_card_model #(
    parameter int MAX_GAP     = 3,
    parameter int IMAGE_DEPTH = 65536
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  sd_block_pkg::sd_read_req_t  req_i,
    input  logic                        fail_en_i,
    input  logic [`SD_BLOCK_ADDR_W-1:0] fail_block_i,
    output sd_block_pkg::sd_read_rsp_t  rsp_o
);
    import sd_block_pkg::*;

    localparam int BLOCK_BYTES = 1 << `SD_BYTE_IDX_W;

    logic [7:0]                  image [0:IMAGE_DEPTH-1];  // Card contents, loaded by the testbench
    logic                        busy;
    logic [`SD_BLOCK_ADDR_W-1:0] blk_addr;
    int                          next_byte;
    int                          gap;
    int                          power_wait;

    always @(posedge clk_i) begin
        if (rst_i) begin
            rsp_o      <= '0;
            rsp_o.idle <= 1'b1;
            busy       <= 1'b0;
            blk_addr   <= '0;
            next_byte  <= 0;
            gap        <= 0;
            power_wait <= 1 + ($urandom % 32);  // Power-down delay after read_finished
        end else begin
            rsp_o.byte_valid <= 1'b0;
            if (!busy) begin
                if (req_i.start) begin
                    busy       <= 1'b1;
                    rsp_o.idle <= 1'b0;  // Busy from the cycle after start
                    blk_addr   <= req_i.block_addr;
                    next_byte  <= 0;
                    gap        <= $urandom % (MAX_GAP + 1);
                end
            end else if (gap > 0) begin
                gap <= gap - 1;
            end else if (next_byte == BLOCK_BYTES) begin
                busy            <= 1'b0;
                rsp_o.idle      <= 1'b1;
                rsp_o.result_ok <= !(fail_en_i && blk_addr == fail_block_i);
            end else begin
                rsp_o.byte_valid <= 1'b1;
                rsp_o.byte_index <= next_byte[`SD_BYTE_IDX_W-1:0];
                rsp_o.data <= image[16'((int'(blk_addr) * BLOCK_BYTES + next_byte) % IMAGE_DEPTH)];
                next_byte        <= next_byte + 1;
                gap              <= $urandom % (MAX_GAP + 1);  // Random gap before the next byte
            end
            if (req_i.read_finished && !rsp_o.powered_down) begin
                if (power_wait == 0) begin
                    rsp_o.powered_down <= 1'b1;
                end else begin
                    power_wait <= power_wait - 1;
                end
            end
        end
    end

endmodule
